// File: qp_ack_handler.sv
`timescale 1ns/100ps
`default_nettype none

module qp_ack_handler import roce_qp_pkg::*; #(
  parameter int MAX_QUEUE_PAIRS = 4
) (
  input  wire          clk,
  input  wire          rst,
  input  wire          ack_valid,
  output logic         ack_ready,
  input  wire rx_ack_t ack,
  output logic         tbl_req_valid,
  input  wire          tbl_req_ready,
  output tbl_req_t     tbl_req
);

  logic     busy;
  logic     pending;
  logic     fatal;
  tbl_req_t req_q;

  // NAK with a nonzero code, PSN sequence errors are not fatal
  assign fatal = (ack.op_code == RC_ACK_OPCODE) && (ack.syndrome[6:5] == 2'b11) &&
                 (ack.syndrome[4:0] != 5'd0);

  assign ack_ready     = !busy;
  assign tbl_req_valid = pending;
  assign tbl_req       = req_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      busy    <= 1'b0;
      pending <= 1'b0;
    end else if (!busy) begin
      if (ack_valid) begin
        busy    <= 1'b1;
        pending <= fatal && qpn_is_local(ack.dest_qpn, MAX_QUEUE_PAIRS);
      end
    end else if (!pending || tbl_req_ready) begin
      busy    <= 1'b0;
      pending <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (!busy && ack_valid) begin
      req_q               <= '0;
      req_q.op            <= TBL_SET_ERROR;
      req_q.idx           <= qpn_index(ack.dest_qpn, MAX_QUEUE_PAIRS);
      req_q.data.state    <= QP_ERROR;
      req_q.data.syndrome <= ack.syndrome;
    end
  end

endmodule

`default_nettype wire

// File: qp_cmd_engine.sv
`timescale 1ns/100ps
`default_nettype none

module qp_cmd_engine import roce_qp_pkg::*; #(
  parameter int MAX_QUEUE_PAIRS = 4
) (
  input  wire              clk,
  input  wire              rst,
  input  wire              cmd_valid,
  output logic             cmd_ready,
  input  wire qp_cmd_t     cmd,
  output logic             status_valid,
  output logic             status_error,
  output logic             tbl_req_valid,
  input  wire              tbl_req_ready,
  output tbl_req_t         tbl_req,
  input  wire              tbl_rsp_valid,
  input  wire qp_context_t tbl_rsp
);

  typedef enum logic [1:0] {IDLE, READ, WAIT, WRITE} state_e;

  state_e   state;
  qp_cmd_t  cmd_q;
  tbl_req_t req_q;
  tbl_req_t wr_req;
  logic     wr_fail;
  logic     fail_q;

  assign cmd_ready     = (state == IDLE);
  assign tbl_req_valid = (state == READ) || (state == WRITE);
  assign tbl_req       = req_q;

  // Check the locked context, a failed check only releases the lock
  always_comb begin
    wr_req     = '0;
    wr_req.op  = TBL_UNLOCK;
    wr_req.idx = req_q.idx;
    wr_fail    = 1'b1;
    case (cmd_q.req_type)
      REQ_OPEN_QP: begin
        if (tbl_rsp.state == QP_RESET) begin
          wr_req.op               = TBL_WRITE_ALL;
          wr_req.data.state       = QP_INIT;
          wr_req.data.rem_ip_addr = cmd_q.rem_ip_addr;
          wr_req.data.rem_qpn     = cmd_q.rem_qpn;
          wr_req.data.loc_qpn     = cmd_q.loc_qpn;
          wr_req.data.rem_psn     = cmd_q.rem_psn;
          wr_req.data.loc_psn     = cmd_q.loc_psn;
          wr_req.data.rem_addr    = cmd_q.rem_addr;
          wr_req.data.r_key       = cmd_q.r_key;
          wr_fail                 = 1'b0;
        end
      end
      REQ_MODIFY_QP_RTS: begin
        if (tbl_rsp.state == QP_INIT) begin
          wr_req.op         = TBL_SET_STATE;
          wr_req.data.state = QP_RTS;
          wr_fail           = 1'b0;
        end
      end
      REQ_CLOSE_QP: begin
        if (tbl_rsp.state != QP_RESET) begin
          wr_req.op         = TBL_SET_STATE;
          wr_req.data.state = QP_RESET;
          wr_fail           = 1'b0;
        end
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state        <= IDLE;
      status_valid <= 1'b0;
      status_error <= 1'b0;
    end else begin
      status_valid <= 1'b0;
      case (state)
        IDLE: begin
          if (cmd_valid) begin
            if (qpn_is_local(cmd.loc_qpn, MAX_QUEUE_PAIRS)) begin
              state <= READ;
            end else begin
              status_valid <= 1'b1;
              status_error <= 1'b1;
            end
          end
        end
        READ: if (tbl_req_ready) state <= WAIT;
        WAIT: if (tbl_rsp_valid) state <= WRITE;
        WRITE: begin
          if (tbl_req_ready) begin
            state        <= IDLE;
            status_valid <= 1'b1;
            status_error <= fail_q;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == IDLE && cmd_valid) begin
      cmd_q <= cmd;
      req_q <= '{op: TBL_READ_LOCK, idx: qpn_index(cmd.loc_qpn, MAX_QUEUE_PAIRS), data: '0};
    end else if (state == WAIT && tbl_rsp_valid) begin
      req_q  <= wr_req;
      fail_q <= wr_fail;
    end
  end

endmodule

`default_nettype wire

// File: qp_context_reader.sv
`timescale 1ns/100ps
`default_nettype none

module qp_context_reader import roce_qp_pkg::*; #(
  parameter int MAX_QUEUE_PAIRS = 4
) (
  input  wire              clk,
  input  wire              rst,
  input  wire              ctx_req_valid,
  output logic             ctx_req_ready,
  input  wire [23:0]       ctx_req_qpn,
  output logic             ctx_rsp_valid,
  output qp_context_t      ctx_rsp,
  output logic             ctx_rsp_error,
  output logic             tbl_req_valid,
  input  wire              tbl_req_ready,
  output tbl_req_t         tbl_req,
  input  wire              tbl_rsp_valid,
  input  wire qp_context_t tbl_rsp
);

  typedef enum logic [1:0] {IDLE, REQ, WAIT} state_e;

  state_e   state;
  tbl_req_t req_q;

  assign ctx_req_ready = (state == IDLE);
  assign tbl_req_valid = (state == REQ);
  assign tbl_req       = req_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      state         <= IDLE;
      ctx_rsp_valid <= 1'b0;
      ctx_rsp_error <= 1'b0;
    end else begin
      ctx_rsp_valid <= 1'b0;
      case (state)
        IDLE: begin
          if (ctx_req_valid) begin
            if (qpn_is_local(ctx_req_qpn, MAX_QUEUE_PAIRS)) begin
              state <= REQ;
            end else begin
              ctx_rsp_valid <= 1'b1;
              ctx_rsp_error <= 1'b1;
            end
          end
        end
        REQ: if (tbl_req_ready) state <= WAIT;
        WAIT: begin
          if (tbl_rsp_valid) begin
            state         <= IDLE;
            ctx_rsp_valid <= 1'b1;
            ctx_rsp_error <= 1'b0;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Zero context goes out with an error response
  always_ff @(posedge clk) begin
    if (state == IDLE && ctx_req_valid) begin
      req_q   <= '{op: TBL_READ, idx: qpn_index(ctx_req_qpn, MAX_QUEUE_PAIRS), data: '0};
      ctx_rsp <= '0;
    end else if (state == WAIT && tbl_rsp_valid) begin
      ctx_rsp <= tbl_rsp;
    end
  end

endmodule

`default_nettype wire

// File: qp_context_table.sv
`timescale 1ns/100ps
`default_nettype none

module qp_context_table import roce_qp_pkg::*; #(
  parameter int MAX_QUEUE_PAIRS = 4
) (
  input  wire              clk,
  input  wire              rst,
  input  wire              req_valid,
  input  wire tbl_req_t    req,
  output qp_context_t      rsp_data
);

  localparam int IDX_W = (MAX_QUEUE_PAIRS > 1) ? $clog2(MAX_QUEUE_PAIRS) : 1;

  qp_context_t      ctx [MAX_QUEUE_PAIRS];
  logic [IDX_W-1:0] idx;

  assign idx = req.idx[IDX_W-1:0];

  always_ff @(posedge clk) begin
    if (rst) begin
      // All queue pairs back to RESET
      for (int i = 0; i < MAX_QUEUE_PAIRS; i++) begin
        ctx[i] <= '0;
      end
    end else if (req_valid) begin
      case (req.op)
        TBL_WRITE_ALL: ctx[idx] <= req.data;
        TBL_SET_STATE: begin
          ctx[idx].state    <= req.data.state;
          ctx[idx].syndrome <= '0;
        end
        TBL_SET_REM_PSN: begin
          ctx[idx].rem_psn  <= req.data.rem_psn;
          ctx[idx].syndrome <= '0;
        end
        TBL_SET_ERROR: begin
          ctx[idx].state    <= QP_ERROR;
          ctx[idx].syndrome <= req.data.syndrome;
        end
        default: ;
      endcase
    end
  end

  // Read data one cycle after the grant
  always_ff @(posedge clk) begin
    if (req_valid) begin
      rsp_data <= ctx[idx];
    end
  end

endmodule

`default_nettype wire

// File: qp_psn_updater.sv
`timescale 1ns/100ps
`default_nettype none

module qp_psn_updater import roce_qp_pkg::*; #(
  parameter int MAX_QUEUE_PAIRS = 4
) (
  input  wire            clk,
  input  wire            rst,
  input  wire            meta_valid,
  output logic           meta_ready,
  input  wire dma_meta_t meta,
  input  wire pmtu_e     pmtu,
  output logic           tbl_req_valid,
  input  wire            tbl_req_ready,
  output tbl_req_t       tbl_req
);

  logic        busy;
  logic        pending;
  logic [3:0]  shift;
  logic [31:0] frac_mask;
  logic [31:0] pkt_cnt;
  tbl_req_t    upd_req;
  tbl_req_t    req_q;

  always_comb begin
    case (pmtu)
      PMTU_256:  shift = 4'd8;
      PMTU_512:  shift = 4'd9;
      PMTU_1024: shift = 4'd10;
      PMTU_2048: shift = 4'd11;
      default:   shift = 4'd12;
    endcase
  end

  // Packets in the transfer, a partial last packet counts as one
  assign frac_mask = (32'd1 << shift) - 32'd1;
  assign pkt_cnt   = (meta.length >> shift) + {31'd0, |(meta.length & frac_mask)};

  always_comb begin
    upd_req              = '0;
    upd_req.op           = TBL_SET_REM_PSN;
    upd_req.idx          = qpn_index(meta.loc_qpn, MAX_QUEUE_PAIRS);
    upd_req.data.rem_psn = meta.rem_psn + pkt_cnt[23:0];
  end

  assign meta_ready    = !busy;
  assign tbl_req_valid = pending;
  assign tbl_req       = req_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      busy    <= 1'b0;
      pending <= 1'b0;
    end else if (!busy) begin
      if (meta_valid) begin
        busy    <= 1'b1;
        pending <= qpn_is_local(meta.loc_qpn, MAX_QUEUE_PAIRS);
      end
    end else if (!pending || tbl_req_ready) begin
      busy    <= 1'b0;
      pending <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (!busy && meta_valid) begin
      req_q <= upd_req;
    end
  end

endmodule

`default_nettype wire

// File: qp_table_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module qp_table_arbiter import roce_qp_pkg::*; (
  input  wire              clk,
  input  wire              rst,

  input  wire              ack_req_valid,
  output logic             ack_req_ready,
  input  wire tbl_req_t    ack_req,
  output logic             ack_rsp_valid,

  input  wire              psn_req_valid,
  output logic             psn_req_ready,
  input  wire tbl_req_t    psn_req,
  output logic             psn_rsp_valid,

  input  wire              cmd_req_valid,
  output logic             cmd_req_ready,
  input  wire tbl_req_t    cmd_req,
  output logic             cmd_rsp_valid,

  input  wire              rd_req_valid,
  output logic             rd_req_ready,
  input  wire tbl_req_t    rd_req,
  output logic             rd_rsp_valid,

  output logic             tbl_req_valid,
  output tbl_req_t         tbl_req,
  input  wire qp_context_t tbl_rsp_data,
  output qp_context_t      rsp_data
);

  // Lower index wins
  localparam int ACK = 0;
  localparam int PSN = 1;
  localparam int CMD = 2;
  localparam int RD  = 3;

  logic [3:0] valid;
  logic [3:0] grant;
  logic [3:0] rsp_owner;
  tbl_req_t   reqs [4];
  logic       locked;

  assign valid     = {rd_req_valid, cmd_req_valid, psn_req_valid, ack_req_valid};
  assign reqs[ACK] = ack_req;
  assign reqs[PSN] = psn_req;
  assign reqs[CMD] = cmd_req;
  assign reqs[RD]  = rd_req;

  always_comb begin
    grant = '0;
    if (locked) begin
      // Read-modify-write in progress, only the command engine may proceed
      grant[CMD] = cmd_req_valid;
    end else begin
      for (int i = 3; i >= 0; i--) begin
        if (valid[i]) begin
          grant = 4'(1 << i);
        end
      end
    end
  end

  always_comb begin
    tbl_req = reqs[ACK];
    for (int i = 0; i < 4; i++) begin
      if (grant[i]) begin
        tbl_req = reqs[i];
      end
    end
  end

  assign tbl_req_valid = |grant;
  assign {rd_req_ready, cmd_req_ready, psn_req_ready, ack_req_ready} = grant;

  always_ff @(posedge clk) begin
    if (rst) begin
      locked    <= 1'b0;
      rsp_owner <= '0;
    end else begin
      if (grant[CMD]) begin
        locked <= (cmd_req.op == TBL_READ_LOCK) || (locked && cmd_req.op == TBL_READ);
      end
      for (int i = 0; i < 4; i++) begin
        rsp_owner[i] <= grant[i] && (reqs[i].op inside {TBL_READ, TBL_READ_LOCK});
      end
    end
  end

  assign {rd_rsp_valid, cmd_rsp_valid, psn_rsp_valid, ack_rsp_valid} = rsp_owner;
  assign rsp_data = tbl_rsp_data;

endmodule

`default_nettype wire

// File: roce_qp_pkg.sv
`default_nettype none

package roce_qp_pkg;

  localparam logic [7:0]  RC_ACK_OPCODE = 8'h11;
  localparam logic [15:0] QPN_BASE_HIGH = 16'd1;

  // Index field of a table request, wide enough for 256 queue pairs
  localparam int TBL_IDX_WIDTH = 8;

  typedef enum logic [2:0] {
    QP_RESET    = 3'd0,
    QP_INIT     = 3'd1,
    QP_RTR      = 3'd2,
    QP_RTS      = 3'd3,
    QP_SQ_DRAIN = 3'd4,
    QP_SQ_ERROR = 3'd5,
    QP_ERROR    = 3'd6
  } qp_state_e;

  typedef enum logic [6:0] {
    REQ_OPEN_QP       = 7'd1,
    REQ_MODIFY_QP_RTS = 7'd2,
    REQ_CLOSE_QP      = 7'd3
  } qp_req_e;

  typedef enum logic [2:0] {
    TBL_READ        = 3'd0,
    TBL_READ_LOCK   = 3'd1,
    TBL_WRITE_ALL   = 3'd2,
    TBL_SET_STATE   = 3'd3,
    TBL_SET_REM_PSN = 3'd4,
    TBL_SET_ERROR   = 3'd5,
    TBL_UNLOCK      = 3'd6
  } tbl_op_e;

  // Codes above 4 are treated as 4096
  typedef enum logic [2:0] {
    PMTU_256  = 3'd0,
    PMTU_512  = 3'd1,
    PMTU_1024 = 3'd2,
    PMTU_2048 = 3'd3,
    PMTU_4096 = 3'd4
  } pmtu_e;

  typedef struct packed {
    qp_state_e   state;
    logic [31:0] rem_ip_addr;
    logic [23:0] rem_qpn;
    logic [23:0] loc_qpn;
    logic [23:0] rem_psn;
    logic [23:0] loc_psn;
    logic [63:0] rem_addr;
    logic [31:0] r_key;
    logic [7:0]  syndrome;
  } qp_context_t;

  typedef struct packed {
    qp_req_e     req_type;
    logic [31:0] r_key;
    logic [23:0] rem_qpn;
    logic [23:0] loc_qpn;
    logic [23:0] rem_psn;
    logic [23:0] loc_psn;
    logic [31:0] rem_ip_addr;
    logic [63:0] rem_addr;
  } qp_cmd_t;

  typedef struct packed {
    logic [31:0] length;
    logic [23:0] loc_qpn;
    logic [23:0] rem_psn;
  } dma_meta_t;

  typedef struct packed {
    logic [7:0]  op_code;
    logic [23:0] psn;
    logic [23:0] dest_qpn;
    logic [7:0]  syndrome;
  } rx_ack_t;

  typedef struct packed {
    tbl_op_e                  op;
    logic [TBL_IDX_WIDTH-1:0] idx;
    qp_context_t              data;
  } tbl_req_t;

  // Local QPNs start at 256
  function automatic logic qpn_is_local(input logic [23:0] qpn, input int unsigned max_qp);
    return (qpn[23:8] == QPN_BASE_HIGH) && (32'(qpn[7:0]) < max_qp);
  endfunction

  function automatic logic [TBL_IDX_WIDTH-1:0] qpn_index(input logic [23:0] qpn,
                                                         input int unsigned max_qp);
    return qpn[7:0] & TBL_IDX_WIDTH'(max_qp - 1);
  endfunction

endpackage

`default_nettype wire

// File: roce_qp_state.f
roce_qp_pkg.sv
qp_context_table.sv
qp_table_arbiter.sv
qp_cmd_engine.sv
qp_psn_updater.sv
qp_ack_handler.sv
qp_context_reader.sv
roce_qp_state_top.sv
roce_qp_state_tb.sv

// File: roce_qp_state_tb.sv
`timescale 1ns/100ps
`default_nettype none

module roce_qp_state_tb import roce_qp_pkg::*; ();

  localparam int          MAX_QP   = 4;
  localparam int          TIMEOUT  = 200;
  localparam int          N_RANDOM = 400;
  localparam int unsigned SEED     = 32'h2f22_a59d;
  localparam time         DRV      = 2;

  logic        clk = 1'b0;
  logic        rst;
  logic        cmd_valid, cmd_ready;
  qp_cmd_t     cmd;
  logic        status_valid, status_error;
  logic        meta_valid, meta_ready;
  dma_meta_t   meta;
  logic        ack_valid, ack_ready;
  rx_ack_t     ack;
  logic        ctx_req_valid, ctx_req_ready;
  logic [23:0] ctx_req_qpn;
  logic        ctx_rsp_valid, ctx_rsp_error;
  qp_context_t ctx_rsp;
  pmtu_e       pmtu;

  qp_context_t model [MAX_QP];
  int          checks = 0;
  int          errors = 0;

  roce_qp_state_top #(.MAX_QUEUE_PAIRS(MAX_QP)) UUT (.*);

  always #10 clk = ~clk;

  task automatic finish_run(input bit timed_out);
    $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timed_out);
    if (errors == 0 && !timed_out) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  endtask

  task automatic stop_on_timeout(input string what);
    $display("Timeout at %0t ns: no %s within %0d cycles", $time, what, TIMEOUT);
    finish_run(1'b1);
  endtask

  function automatic logic qpn_in_table(input logic [23:0] qpn);
    return (qpn[23:8] == 16'd1) && (qpn[7:0] < MAX_QP);
  endfunction

  function automatic logic [23:0] random_qpn(input bit in_range);
    logic [15:0] high;
    if (in_range) begin
      return {16'd1, 8'($urandom_range(MAX_QP - 1))};
    end
    if ($urandom_range(1) == 0) begin
      return {16'd1, 8'($urandom_range(255, MAX_QP))};
    end
    high = 16'($urandom);
    if (high == 16'd1) begin
      high = 16'd2;
    end
    return {high, 8'($urandom)};
  endfunction

  function automatic qp_cmd_t random_command(input logic [23:0] qpn);
    qp_cmd_t c;
    case ($urandom_range(2))
      0:       c.req_type = REQ_OPEN_QP;
      1:       c.req_type = REQ_MODIFY_QP_RTS;
      default: c.req_type = REQ_CLOSE_QP;
    endcase
    c.r_key       = $urandom;
    c.rem_qpn     = 24'($urandom);
    c.loc_qpn     = qpn;
    c.rem_psn     = 24'($urandom);
    c.loc_psn     = 24'($urandom);
    c.rem_ip_addr = $urandom;
    c.rem_addr    = {$urandom, $urandom};
    return c;
  endfunction

  // Packets of the transfer, rounded up, added to the start PSN
  function automatic logic [23:0] expected_psn(input dma_meta_t m, input logic [2:0] code);
    longint unsigned mtu;
    longint unsigned pkts;
    mtu  = (code > 3'd4) ? 4096 : (256 << code);
    pkts = (m.length + mtu - 1) / mtu;
    return 24'(m.rem_psn + pkts);
  endfunction

  task automatic issue_command(input qp_cmd_t c, output logic err);
    int t;
    @(posedge clk);
    #DRV;
    cmd       = c;
    cmd_valid = 1'b1;
    t = 0;
    do begin
      @(negedge clk);
      t++;
    end while (!cmd_ready && t < TIMEOUT);
    if (!cmd_ready) stop_on_timeout("cmd_ready");
    @(posedge clk);
    #DRV;
    cmd_valid = 1'b0;
    t = 0;
    do begin
      @(negedge clk);
      t++;
    end while (!status_valid && t < TIMEOUT);
    if (!status_valid) stop_on_timeout("status_valid");
    err = status_error;
  endtask

  task automatic read_context(input logic [23:0] qpn, output qp_context_t ctx,
                              output logic err);
    int t;
    @(posedge clk);
    #DRV;
    ctx_req_qpn   = qpn;
    ctx_req_valid = 1'b1;
    t = 0;
    do begin
      @(negedge clk);
      t++;
    end while (!ctx_req_ready && t < TIMEOUT);
    if (!ctx_req_ready) stop_on_timeout("ctx_req_ready");
    @(posedge clk);
    #DRV;
    ctx_req_valid = 1'b0;
    t = 0;
    do begin
      @(negedge clk);
      t++;
    end while (!ctx_rsp_valid && t < TIMEOUT);
    if (!ctx_rsp_valid) stop_on_timeout("ctx_rsp_valid");
    ctx = ctx_rsp;
    err = ctx_rsp_error;
  endtask

  // Returns once the updater is ready again, so its write has landed
  task automatic push_meta(input dma_meta_t m, input logic [2:0] code);
    int t;
    @(posedge clk);
    #DRV;
    pmtu       = pmtu_e'(code);
    meta       = m;
    meta_valid = 1'b1;
    t = 0;
    do begin
      @(negedge clk);
      t++;
    end while (!meta_ready && t < TIMEOUT);
    if (!meta_ready) stop_on_timeout("meta_ready");
    @(posedge clk);
    #DRV;
    meta_valid = 1'b0;
    t = 0;
    do begin
      @(negedge clk);
      t++;
    end while (!meta_ready && t < TIMEOUT);
    if (!meta_ready) stop_on_timeout("meta_ready after transfer");
  endtask

  task automatic push_ack(input rx_ack_t a);
    int t;
    @(posedge clk);
    #DRV;
    ack       = a;
    ack_valid = 1'b1;
    t = 0;
    do begin
      @(negedge clk);
      t++;
    end while (!ack_ready && t < TIMEOUT);
    if (!ack_ready) stop_on_timeout("ack_ready");
    @(posedge clk);
    #DRV;
    ack_valid = 1'b0;
    t = 0;
    do begin
      @(negedge clk);
      t++;
    end while (!ack_ready && t < TIMEOUT);
    if (!ack_ready) stop_on_timeout("ack_ready after transfer");
  endtask

  task automatic model_command(input qp_cmd_t c, output logic exp_err);
    int idx;
    exp_err = 1'b1;
    if (qpn_in_table(c.loc_qpn)) begin
      idx = c.loc_qpn[7:0];
      if (c.req_type == REQ_OPEN_QP && model[idx].state == QP_RESET) begin
        model[idx].state       = QP_INIT;
        model[idx].rem_ip_addr = c.rem_ip_addr;
        model[idx].rem_qpn     = c.rem_qpn;
        model[idx].loc_qpn     = c.loc_qpn;
        model[idx].rem_psn     = c.rem_psn;
        model[idx].loc_psn     = c.loc_psn;
        model[idx].rem_addr    = c.rem_addr;
        model[idx].r_key       = c.r_key;
        model[idx].syndrome    = 8'd0;
        exp_err = 1'b0;
      end else if (c.req_type == REQ_MODIFY_QP_RTS && model[idx].state == QP_INIT) begin
        model[idx].state    = QP_RTS;
        model[idx].syndrome = 8'd0;
        exp_err = 1'b0;
      end else if (c.req_type == REQ_CLOSE_QP && model[idx].state != QP_RESET) begin
        model[idx].state    = QP_RESET;
        model[idx].syndrome = 8'd0;
        exp_err = 1'b0;
      end
    end
  endtask

  // Reads back the touched entry, or any entry when the QPN was foreign
  task automatic compare_context(input logic [23:0] qpn);
    qp_context_t got;
    logic        err;
    int          idx;
    idx = qpn_in_table(qpn) ? int'(qpn[7:0]) : int'($urandom_range(MAX_QP - 1));
    read_context({16'd1, 8'(idx)}, got, err);
    checks++;
    assert (!err && got == model[idx])
      else begin
        errors++;
        $display("[ERROR] %0t ns: QP %0d context %h err %0b, expected %h",
                 $time, idx, got, err, model[idx]);
      end
  endtask

  task automatic test_command(input qp_cmd_t c);
    logic err;
    logic exp_err;
    model_command(c, exp_err);
    issue_command(c, err);
    checks++;
    assert (err == exp_err)
      else begin
        errors++;
        $display("[ERROR] %0t ns: command %s on QPN %h status_error %0b, expected %0b",
                 $time, c.req_type.name(), c.loc_qpn, err, exp_err);
      end
    compare_context(c.loc_qpn);
  endtask

  initial begin
    qp_cmd_t     c;
    dma_meta_t   m;
    rx_ack_t     a;
    qp_context_t got;
    logic        err;
    logic [2:0]  code;
    logic [23:0] qpn;
    int          kind;

    void'($urandom(SEED));
    rst           = 1'b1;
    cmd_valid     = 1'b0;
    cmd           = '0;
    meta_valid    = 1'b0;
    meta          = '0;
    ack_valid     = 1'b0;
    ack           = '0;
    ctx_req_valid = 1'b0;
    ctx_req_qpn   = '0;
    pmtu          = PMTU_256;
    for (int i = 0; i < MAX_QP; i++) begin
      model[i] = '0;
    end
    repeat (5) @(posedge clk);
    #DRV;
    rst = 1'b0;

    // Full lifecycle on every queue pair, each command twice
    for (int i = 0; i < MAX_QP; i++) begin
      c = random_command({16'd1, 8'(i)});
      c.req_type = REQ_OPEN_QP;
      test_command(c);
      c.req_type = REQ_OPEN_QP;
      c.r_key    = ~c.r_key;
      test_command(c);
      c.req_type = REQ_MODIFY_QP_RTS;
      test_command(c);
      test_command(c);
      c.req_type = REQ_CLOSE_QP;
      test_command(c);
      test_command(c);
    end

    for (int n = 0; n < N_RANDOM; n++) begin
      qpn = random_qpn($urandom_range(7) != 0);
      case ($urandom_range(9))
        0, 1, 2, 3: begin
          test_command(random_command(qpn));
        end
        4, 5: begin
          m.length  = ($urandom_range(1) == 0) ? $urandom : $urandom_range(20000);
          m.loc_qpn = qpn;
          m.rem_psn = 24'($urandom);
          code      = 3'($urandom_range(7));
          if (qpn_in_table(qpn)) begin
            model[qpn[7:0]].rem_psn  = expected_psn(m, code);
            model[qpn[7:0]].syndrome = 8'd0;
          end
          push_meta(m, code);
          compare_context(qpn);
        end
        6, 7, 8: begin
          a.psn      = 24'($urandom);
          a.dest_qpn = qpn;
          kind       = $urandom_range(3);
          case (kind)
            // Fatal NAK
            0: begin
              a.op_code  = RC_ACK_OPCODE;
              a.syndrome = {1'($urandom), 2'b11, 5'($urandom_range(31, 1))};
            end
            // Plain ACK
            1: begin
              a.op_code  = RC_ACK_OPCODE;
              a.syndrome = {1'($urandom), 2'b00, 5'($urandom)};
            end
            // PSN sequence NAK
            2: begin
              a.op_code  = RC_ACK_OPCODE;
              a.syndrome = 8'h60;
            end
            default: begin
              a.op_code  = 8'($urandom_range(255, 18));
              a.syndrome = 8'($urandom);
            end
          endcase
          if (kind == 0 && qpn_in_table(qpn)) begin
            model[qpn[7:0]].state    = QP_ERROR;
            model[qpn[7:0]].syndrome = a.syndrome;
          end
          push_ack(a);
          compare_context(qpn);
        end
        default: begin
          qpn = random_qpn(1'b0);
          read_context(qpn, got, err);
          checks++;
          assert (err && got == '0)
            else begin
              errors++;
              $display("[ERROR] %0t ns: read of foreign QPN %h gave err %0b context %h",
                       $time, qpn, err, got);
            end
        end
      endcase
    end

    finish_run(1'b0);
  end

endmodule

`default_nettype wire

// File: roce_qp_state_top.sv
`timescale 1ns/100ps
`default_nettype none

module roce_qp_state_top import roce_qp_pkg::*; #(
  parameter int MAX_QUEUE_PAIRS = 4
) (
  input  wire            clk,
  input  wire            rst,
  input  wire            cmd_valid,
  output logic           cmd_ready,
  input  wire qp_cmd_t   cmd,
  output logic           status_valid,
  output logic           status_error,
  input  wire            meta_valid,
  output logic           meta_ready,
  input  wire dma_meta_t meta,
  input  wire            ack_valid,
  output logic           ack_ready,
  input  wire rx_ack_t   ack,
  input  wire            ctx_req_valid,
  output logic           ctx_req_ready,
  input  wire [23:0]     ctx_req_qpn,
  output logic           ctx_rsp_valid,
  output qp_context_t    ctx_rsp,
  output logic           ctx_rsp_error,
  input  wire pmtu_e     pmtu
);

  logic        ack_req_valid, ack_req_ready;
  logic        psn_req_valid, psn_req_ready;
  logic        cmd_req_valid, cmd_req_ready, cmd_rsp_valid;
  logic        rd_req_valid, rd_req_ready, rd_rsp_valid;
  tbl_req_t    ack_req, psn_req, cmd_req, rd_req;
  logic        tbl_req_valid;
  tbl_req_t    tbl_req;
  qp_context_t tbl_rsp_data, rsp_data;

  qp_ack_handler #(.MAX_QUEUE_PAIRS(MAX_QUEUE_PAIRS)) u_ack (
    .clk, .rst, .ack_valid, .ack_ready, .ack,
    .tbl_req_valid(ack_req_valid), .tbl_req_ready(ack_req_ready), .tbl_req(ack_req)
  );

  qp_psn_updater #(.MAX_QUEUE_PAIRS(MAX_QUEUE_PAIRS)) u_psn (
    .clk, .rst, .meta_valid, .meta_ready, .meta, .pmtu,
    .tbl_req_valid(psn_req_valid), .tbl_req_ready(psn_req_ready), .tbl_req(psn_req)
  );

  qp_cmd_engine #(.MAX_QUEUE_PAIRS(MAX_QUEUE_PAIRS)) u_cmd (
    .clk, .rst, .cmd_valid, .cmd_ready, .cmd, .status_valid, .status_error,
    .tbl_req_valid(cmd_req_valid), .tbl_req_ready(cmd_req_ready), .tbl_req(cmd_req),
    .tbl_rsp_valid(cmd_rsp_valid), .tbl_rsp(rsp_data)
  );

  qp_context_reader #(.MAX_QUEUE_PAIRS(MAX_QUEUE_PAIRS)) u_rd (
    .clk, .rst, .ctx_req_valid, .ctx_req_ready, .ctx_req_qpn,
    .ctx_rsp_valid, .ctx_rsp, .ctx_rsp_error,
    .tbl_req_valid(rd_req_valid), .tbl_req_ready(rd_req_ready), .tbl_req(rd_req),
    .tbl_rsp_valid(rd_rsp_valid), .tbl_rsp(rsp_data)
  );

  // Write-only peers never see a response
  qp_table_arbiter u_arb (
    .clk, .rst,
    .ack_req_valid, .ack_req_ready, .ack_req, .ack_rsp_valid(),
    .psn_req_valid, .psn_req_ready, .psn_req, .psn_rsp_valid(),
    .cmd_req_valid, .cmd_req_ready, .cmd_req, .cmd_rsp_valid,
    .rd_req_valid, .rd_req_ready, .rd_req, .rd_rsp_valid,
    .tbl_req_valid, .tbl_req, .tbl_rsp_data, .rsp_data
  );

  qp_context_table #(.MAX_QUEUE_PAIRS(MAX_QUEUE_PAIRS)) u_tbl (
    .clk, .rst, .req_valid(tbl_req_valid), .req(tbl_req), .rsp_data(tbl_rsp_data)
  );

endmodule

`default_nettype wire
